// File: filelist.f
hdl/elink_pkg.sv
hdl/rx_io_pkg.sv
hdl/rx_ddr_sampler.sv
hdl/rx_frame_assembler.sv
hdl/rx_packet_unpacker.sv
hdl/rx_slow_handoff.sv
hdl/erx_io.sv
tb/tb_clock_gen.sv
tb/tb_erx_io.sv

// File: Makefile
TOP := tb_erx_io

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "Test failed" sim.log

obj_dir/V$(TOP): filelist.f $(wildcard hdl/*.sv tb/*.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall $(shell grep '^hdl/' filelist.f) --top-module erx_io

clean:
	rm -rf obj_dir sim.log

// File: tb/tb_erx_io.sv
`timescale 1ns/10ps

module tb_erx_io;

   localparam int DRAIN_LIMIT = 200;   // cycles to wait for queued packets
   localparam int QUIET_LIMIT = 60;    // silence window after a short frame
   localparam elink_pkg::packet_t HDR_MASK = elink_pkg::packet_t'(40'hff_ffff_ffff);

   // first packet, then two bursts of four
   localparam rx_io_pkg::word_t FIXED_WORDS [15] = '{
      16'h5a31, 16'hc4e7, 16'h0b96, 16'h7d28, 16'hf1a3, 16'h3c5e, 16'h82d4,
      16'h19be, 16'h6f40, 16'hd273, 16'ha58c, 16'h4e0d, 16'hb7f2, 16'h2861, 16'he39a};

   logic               rx_lclk;
   logic               arst_n;
   logic               force_rst;
   logic               rxi_frame;
   rx_io_pkg::lane_t   rxi_data;
   logic               rx_access;
   logic               rx_burst;
   elink_pkg::packet_t rx_packet;

   int                 seed = 32'hef39342a;
   int                 errors = 0;
   int                 checks = 0;
   int                 packet_events = 0;
   rx_io_pkg::word_t   frame_words [$];
   rx_io_pkg::sample_t model_sample;     // tb copy of the sample register
   elink_pkg::packet_t exp_pkt_q [$];
   logic               exp_burst_q [$];
   elink_pkg::packet_t got_q [$];        // packets seen in the current test

   tb_clock_gen #(.RST_CYCLES (4)) u_clk (
      .force_rst (force_rst),
      .rx_lclk   (rx_lclk),
      .arst_n    (arst_n)
   );

   erx_io #(.SLOW_RATIO (4)) u_dut (
      .rx_lclk   (rx_lclk),
      .arst_n    (arst_n),
      .rxi_frame (rxi_frame),
      .rxi_data  (rxi_data),
      .rx_access (rx_access),
      .rx_burst  (rx_burst),
      .rx_packet (rx_packet)
   );

   //##################################################
   //# reference model
   //##################################################

   // wire bytes are msb first for data and srcaddr
   function automatic elink_pkg::packet_t expected_packet(input rx_io_pkg::sample_t s);
      elink_pkg::packet_t p;
      int                 j;
      p      = '0;
      p[0]   = s[40];        // access
      p[1]   = s[41];        // write
      p[3:2] = s[43:42];     // datamode
      p[7:4] = s[15:12];     // ctrlmode
      p[39:36] = s[11:8];    // dstaddr top nibble
      for (j = 0; j < 3; j++)
         p[28 - 8*j +: 8] = s[16 + 8*j +: 8];
      p[11:8] = s[47:44];    // dstaddr low nibble
      for (j = 0; j < 4; j++)
      begin
         p[40 + 8*(3-j) +: 8] = s[48 + 8*j +: 8];   // data
         p[72 + 8*(3-j) +: 8] = s[80 + 8*j +: 8];   // srcaddr
      end
      return p;
   endfunction

   //##################################################
   //# checks
   //##################################################

   task automatic check_packet(input string name, input elink_pkg::packet_t exp,
                               input elink_pkg::packet_t act);
      checks++;
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp)
      begin
         $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
         errors++;
      end
   endtask

   task automatic count_packets(input string what, input int expected);
      checks++;
      if (got_q.size() != expected)
      begin
         $display("%s gave %0d packets instead of %0d", what, got_q.size(), expected);
         errors++;
      end
   endtask

   //##################################################
   //# stimulus
   //##################################################

   task automatic random_words(input int n);
      int k;
      int r;
      frame_words.delete();
      for (k = 0; k < n; k++)
      begin
         r = $random(seed);
         frame_words.push_back(r[15:0]);
      end
   endtask

   task automatic load_fixed(input int n);
      int k;
      frame_words.delete();
      for (k = 0; k < n; k++)
         frame_words.push_back(FIXED_WORDS[k]);
   endtask

   // frame is sampled one cycle ahead of its byte pair
   task automatic send_frame(input int n, input bit hold_frame);
      int               k;
      int               slot;
      logic             later;
      rx_io_pkg::word_t w;
      slot  = 0;
      later = 1'b0;
      @(posedge rx_lclk);
      #1 rxi_frame = 1'b1;                      // lead cycle
      for (k = 0; k < n; k++)
      begin
         w = frame_words[k];
         @(posedge rx_lclk);
         #1;
         rxi_data  = w[7:0];                    // even byte, high half
         rxi_frame = hold_frame || (k + 1 < n);
         @(negedge rx_lclk);
         #1 rxi_data = w[15:8];                 // odd byte, low half
         model_sample[slot*16 +: 16] = w;
         if (slot == rx_io_pkg::SAMPLE_WORDS - 1)
         begin
            exp_pkt_q.push_back(expected_packet(model_sample));
            exp_burst_q.push_back(later);       // first of a frame is 0
            later = 1'b1;
            slot  = rx_io_pkg::BURST_RELOAD;    // words 0..2 kept
         end
         else
            slot++;
      end
      @(posedge rx_lclk);
      #1 rxi_data = '0;
   endtask

   //##################################################
   //# bounded waits
   //##################################################

   task automatic drain_queue(input string what);
      int cnt;
      cnt = 0;
      while (exp_pkt_q.size() != 0 && cnt < DRAIN_LIMIT)
      begin
         @(posedge rx_lclk);
         cnt++;
      end
      if (exp_pkt_q.size() != 0)
      begin
         $display("Timeout at %0t in %s: no packet arrived within %0d cycles, %0d missing",
                  $time, what, DRAIN_LIMIT, exp_pkt_q.size());
         errors++;
         exp_pkt_q.delete();
         exp_burst_q.delete();
      end
      cnt = 0;
      while (rx_access !== 1'b0 && cnt < QUIET_LIMIT)   // drops one slow period later
      begin
         @(negedge rx_lclk);
         cnt++;
      end
      if (rx_access !== 1'b0)
      begin
         $display("rx_access still high at %0t after the last packet of %s", $time, what);
         errors++;
      end
   endtask

   task automatic expect_silence();
      int seen;
      int cnt;
      seen = packet_events;
      cnt  = 0;
      while (packet_events == seen && cnt < QUIET_LIMIT)
      begin
         @(posedge rx_lclk);
         cnt++;
      end
      if (packet_events != seen)
      begin
         $display("Packet at %0t after a frame that ended early", $time);
         errors++;
      end
      if (exp_pkt_q.size() != 0)
      begin
         $display("Model queued a packet for a frame that ended early");
         errors++;
      end
   endtask

   task automatic hold_for_reset();
      int cnt;
      cnt = 0;
      while (arst_n !== 1'b1 && cnt < 50)
      begin
         @(posedge rx_lclk);
         cnt++;
      end
      if (arst_n !== 1'b1)
      begin
         $display("Reset still asserted after %0d cycles", cnt);
         errors++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int start);
      $display("test %0d %-22s done at %0t, %0d error(s)", num, name, $time, errors - start);
   endtask

   //##################################################
   //# compare process
   //##################################################

   // a new packet shows as access rising or the packet changing on a tick
   initial
   begin
      elink_pkg::packet_t exp_p;
      elink_pkg::packet_t prev_packet;
      logic               exp_b;
      logic               prev_access;
      prev_access = 1'b0;
      prev_packet = '0;
      forever
      begin
         @(negedge rx_lclk);                    // outputs settled
         if (arst_n && rx_access && (!prev_access || rx_packet !== prev_packet))
         begin
            packet_events++;
            got_q.push_back(rx_packet);
            if (exp_pkt_q.size() == 0)
            begin
               $display("Unexpected packet at %0t: rx_packet %h with nothing queued",
                        $time, rx_packet);
               errors++;
            end
            else
            begin
               exp_p = exp_pkt_q.pop_front();
               exp_b = exp_burst_q.pop_front();
               check_packet("rx_packet", exp_p, rx_packet);
               check_flag("rx_burst", exp_b, rx_burst);
            end
         end
         prev_access = rx_access;
         prev_packet = rx_packet;
      end
   end

   //##################################################
   //# test sequence
   //##################################################

   initial
   begin
      int                 start;
      int                 f;
      rx_io_pkg::sample_t first_sample;
      elink_pkg::packet_t hdr_exp;
      rxi_frame = 1'b0;
      rxi_data  = '0;
      force_rst = 1'b0;
      hold_for_reset();

      start = errors;                           // idle outputs
      @(negedge rx_lclk);
      check_flag("rx_access", 1'b0, rx_access);
      check_flag("rx_burst", 1'b0, rx_burst);
      check_packet("rx_packet", '0, rx_packet);
      report_test(1, "reset values", start);

      start = errors;
      got_q.delete();
      load_fixed(7);
      send_frame(7, 1'b0);
      drain_queue("single frame");
      count_packets("single frame", 1);
      report_test(2, "single frame", start);

      start = errors;
      got_q.delete();
      for (f = 0; f < 20; f++)
      begin
         random_words(7);
         send_frame(7, 1'b0);
         repeat (4) @(posedge rx_lclk);         // frame gap
      end
      drain_queue("random frames");
      count_packets("random frames", 20);
      report_test(3, "random frames", start);

      start = errors;
      got_q.delete();
      load_fixed(15);
      send_frame(15, 1'b0);                     // 7 + 4 + 4
      drain_queue("burst frame");
      count_packets("burst frame", 3);
      // header fields all come from words 0..2 of the first packet
      for (f = 0; f < rx_io_pkg::SAMPLE_WORDS; f++)
         first_sample[f*16 +: 16] = FIXED_WORDS[f];
      hdr_exp = expected_packet(first_sample) & HDR_MASK;
      if (got_q.size() == 3)
      begin
         check_packet("rx_packet[39:0] packet 2", hdr_exp, got_q[1] & HDR_MASK);
         check_packet("rx_packet[39:0] packet 3", hdr_exp, got_q[2] & HDR_MASK);
      end
      report_test(4, "burst frame", start);

      start = errors;
      got_q.delete();
      random_words(4);
      send_frame(4, 1'b0);                      // drops before word 6
      expect_silence();
      random_words(7);
      send_frame(7, 1'b0);
      drain_queue("frame after short frame");
      count_packets("short then full frame", 1);
      report_test(5, "short frame", start);

      start = errors;
      got_q.delete();
      random_words(3);
      send_frame(3, 1'b1);                      // frame left open
      if (rx_packet === '0)
      begin
         $display("rx_packet was already zero before the mid-frame reset");
         errors++;
      end
      @(posedge rx_lclk);
      #1;
      force_rst = 1'b1;
      rxi_frame = 1'b0;
      @(negedge rx_lclk);
      check_flag("rx_access", 1'b0, rx_access);
      check_flag("rx_burst", 1'b0, rx_burst);
      check_packet("rx_packet", '0, rx_packet);
      repeat (3) @(posedge rx_lclk);
      #1 force_rst = 1'b0;
      repeat (4) @(posedge rx_lclk);
      random_words(7);
      send_frame(7, 1'b0);
      drain_queue("frame after reset");
      count_packets("frame after reset", 1);
      report_test(6, "mid-frame reset", start);

      $display("%0d checks, %0d packets, %0d errors", checks, packet_events, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen
#(
   parameter int RST_CYCLES = 4   // power on reset length
)
(
   input  logic force_rst,   // extra reset from the test sequence
   output logic rx_lclk,
   output logic arst_n
);

   logic por_n;

   initial
   begin
      rx_lclk = 1'b0;
      forever
         #4 rx_lclk = ~rx_lclk;   // 8 ns period
   end

   initial
   begin
      por_n = 1'b0;
      repeat (RST_CYCLES) @(posedge rx_lclk);
      #1 por_n = 1'b1;            // release just after an edge
   end

   assign arst_n = por_n & ~force_rst;

endmodule

// File: hdl/erx_io.sv
`timescale 1ns/10ps

module erx_io
#(
   parameter int SLOW_RATIO = 4   // burst stream lossless at 4
)
(
   input  logic               rx_lclk,
   input  logic               arst_n,
   input  logic               rxi_frame,
   input  rx_io_pkg::lane_t   rxi_data,
   output logic               rx_access,
   output logic               rx_burst,
   output elink_pkg::packet_t rx_packet
);

   rx_io_pkg::word_t   rx_word;
   logic               rx_frame;
   rx_io_pkg::sample_t rx_sample;
   logic               access;
   logic               burst_detect;
   elink_pkg::packet_t packet_fast;
   logic               burst_fast;
   logic               valid;

   //##################################################
   //# fast domain pipeline
   //##################################################

   rx_ddr_sampler u_sampler (
      .rx_lclk   (rx_lclk),
      .arst_n    (arst_n),
      .rxi_data  (rxi_data),
      .rxi_frame (rxi_frame),
      .rx_word   (rx_word),
      .rx_frame  (rx_frame)
   );

   rx_frame_assembler u_assembler (
      .rx_lclk      (rx_lclk),
      .arst_n       (arst_n),
      .rx_word      (rx_word),
      .rx_frame     (rx_frame),
      .rx_sample    (rx_sample),
      .access       (access),
      .burst_detect (burst_detect)
   );

   rx_packet_unpacker u_unpacker (
      .rx_lclk      (rx_lclk),
      .arst_n       (arst_n),
      .rx_sample    (rx_sample),
      .access       (access),
      .burst_detect (burst_detect),
      .packet_fast  (packet_fast),
      .burst_fast   (burst_fast),
      .valid        (valid)
   );

   // slow phase handoff to the consumer
   rx_slow_handoff #(
      .SLOW_RATIO (SLOW_RATIO)
   ) u_handoff (
      .rx_lclk     (rx_lclk),
      .arst_n      (arst_n),
      .valid       (valid),
      .packet_fast (packet_fast),
      .burst_fast  (burst_fast),
      .rx_access   (rx_access),
      .rx_burst    (rx_burst),
      .rx_packet   (rx_packet)
   );

endmodule

// File: hdl/rx_slow_handoff.sv
`timescale 1ns/10ps

module rx_slow_handoff
#(
   parameter int SLOW_RATIO = 4   // fast cycles per slow period
)
(
   input  logic               rx_lclk,
   input  logic               arst_n,
   input  logic               valid,
   input  elink_pkg::packet_t packet_fast,
   input  logic               burst_fast,
   output logic               rx_access,
   output logic               rx_burst,
   output elink_pkg::packet_t rx_packet
);

   localparam int             CW   = $clog2(SLOW_RATIO);
   localparam logic [CW-1:0]  LAST = CW'(SLOW_RATIO - 1);

   logic [CW-1:0] phase;      // position inside slow period
   logic [CW-1:0] hold_cnt;   // remaining stretch cycles
   logic          tick;       // last fast cycle of the period
   logic          valid_wide;

   assign tick       = (phase == LAST);
   assign valid_wide = valid | (hold_cnt != '0);   // SLOW_RATIO cycles wide

   //##################################################
   //# counters
   //##################################################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         phase    <= '0;
         hold_cnt <= '0;
      end
      else
      begin
         phase <= tick ? '0 : phase + 1'b1;
         if (valid)
            hold_cnt <= LAST;              // covers the following cycles
         else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;
      end
   end

   //##################################################
   //# slow side outputs
   //##################################################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rx_access <= 1'b0;
         rx_burst  <= 1'b0;
         rx_packet <= '0;
      end
      else if (tick)
      begin
         rx_access <= valid_wide;
         if (valid_wide)
         begin
            rx_packet <= packet_fast;   // still stable inside the window
            rx_burst  <= burst_fast;
         end
      end
   end

   // consumer sees one packet per slow period
   a_pkt_hold : assert property (@(posedge rx_lclk) disable iff (!arst_n)
      !tick |=> $stable(rx_packet));

endmodule

// File: hdl/rx_packet_unpacker.sv
`timescale 1ns/10ps

module rx_packet_unpacker
(
   input  logic                rx_lclk,
   input  logic                arst_n,
   input  rx_io_pkg::sample_t  rx_sample,
   input  logic                access,
   input  logic                burst_detect,
   output elink_pkg::packet_t  packet_fast,
   output logic                burst_fast,
   output logic                valid          // packet_fast just loaded
);

   logic                  pkt_access;
   logic                  pkt_write;
   elink_pkg::datamode_t  datamode;
   elink_pkg::ctrlmode_t  ctrlmode;
   elink_pkg::addr_t      dstaddr;
   elink_pkg::data_t      data;
   elink_pkg::addr_t      srcaddr;

   //##################################################
   //# field extraction
   //##################################################

   assign pkt_access = rx_sample[40];
   assign pkt_write  = rx_sample[41];
   assign datamode   = rx_sample[43:42];
   assign ctrlmode   = rx_sample[15:12];

   // dstaddr is split over the first three words
   assign dstaddr = {rx_sample[11:8],
                     rx_sample[23:16],
                     rx_sample[31:24],
                     rx_sample[39:32],
                     rx_sample[47:44]};

   // bytes arrive msb first on the wire
   assign data    = {rx_sample[55:48], rx_sample[63:56],
                     rx_sample[71:64], rx_sample[79:72]};
   assign srcaddr = {rx_sample[87:80], rx_sample[95:88],
                     rx_sample[103:96], rx_sample[111:104]};

   //##################################################
   //# packet hold
   //##################################################

   always_ff @(posedge rx_lclk)
   begin
      if (access)
         packet_fast <= {srcaddr, data, dstaddr, ctrlmode, datamode,
                         pkt_write, pkt_access};
   end

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         burst_fast <= 1'b0;
         valid      <= 1'b0;
      end
      else
      begin
         if (access)
            burst_fast <= burst_detect;   // old value, first packet gets 0
         valid <= access;                 // one cycle behind access
      end
   end

   // packets are at least four words apart
   a_valid_pulse : assert property (@(posedge rx_lclk) disable iff (!arst_n)
      valid |=> !valid);

endmodule

// File: hdl/rx_frame_assembler.sv
`timescale 1ns/10ps

module rx_frame_assembler
(
   input  logic               rx_lclk,
   input  logic               arst_n,
   input  rx_io_pkg::word_t   rx_word,
   input  logic               rx_frame,
   output rx_io_pkg::sample_t rx_sample,
   output logic               access,        // one cycle per full sample
   output logic               burst_detect   // frame ran past a packet
);

   localparam int SAMPLE_WORDS = rx_io_pkg::SAMPLE_WORDS;
   localparam int WORD_W       = rx_io_pkg::WORD_W;
   localparam int LAST         = SAMPLE_WORDS - 1;

   localparam rx_io_pkg::ptr_t PTR_FIRST  = rx_io_pkg::ptr_t'(1);
   localparam rx_io_pkg::ptr_t PTR_RELOAD =
      rx_io_pkg::ptr_t'(1) << rx_io_pkg::BURST_RELOAD;

   rx_io_pkg::ptr_t wr_ptr;   // one hot slot select

   //##################################################
   //# write pointer
   //##################################################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
         wr_ptr <= PTR_FIRST;
      else if (!rx_frame)
         wr_ptr <= PTR_FIRST;                  // idle, wait for new frame
      else if (wr_ptr[LAST])
         wr_ptr <= PTR_RELOAD;                 // expect burst words next
      else
         wr_ptr <= {wr_ptr[LAST-1:0], 1'b0};   // next slot
   end

   //##################################################
   //# sample register
   //##################################################

   // words 0..2 survive a reload, so burst packets keep the header
   always_ff @(posedge rx_lclk)
   begin
      if (rx_frame)
      begin
         for (int i = 0; i < SAMPLE_WORDS; i++)
         begin
            if (wr_ptr[i])
               rx_sample[i*WORD_W +: WORD_W] <= rx_word;
         end
      end
   end

   //##################################################
   //# access strobe and burst tracking
   //##################################################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         access       <= 1'b0;
         burst_detect <= 1'b0;
      end
      else
      begin
         access <= wr_ptr[LAST] & rx_frame;   // last slot just written
         if (access && rx_frame)
            burst_detect <= 1'b1;             // still framed after a packet
         else if (!rx_frame)
            burst_detect <= 1'b0;
      end
   end

   // pointer must never lose or duplicate its token
   a_ptr_onehot : assert property (@(posedge rx_lclk) disable iff (!arst_n)
      $onehot(wr_ptr));

endmodule

// File: hdl/rx_ddr_sampler.sv
`timescale 1ns/10ps

module rx_ddr_sampler
(
   input  logic             rx_lclk,
   input  logic             arst_n,
   input  rx_io_pkg::lane_t rxi_data,   // one byte per clock edge
   input  logic             rxi_frame,
   output rx_io_pkg::word_t rx_word,    // {odd, even}
   output logic             rx_frame
);

   rx_io_pkg::lane_t even_fall;   // caught at the falling edge
   rx_io_pkg::lane_t even_q;      // realigned to rising edge
   rx_io_pkg::lane_t odd_q;       // caught at the rising edge
   logic             frame_s0;
   logic             frame_s1;

   //##################################################
   //# data lanes
   //##################################################

   // even byte is driven in the high half
   always_ff @(negedge rx_lclk)
      even_fall <= rxi_data;

   // same edge pipelined, both halves leave together
   always_ff @(posedge rx_lclk)
   begin
      even_q  <= even_fall;
      odd_q   <= rxi_data;            // odd byte from the low half
      rx_word <= {odd_q, even_q};     // first byte in low half
   end

   //##################################################
   //# frame, matched to the word latency
   //##################################################

   always_ff @(posedge rx_lclk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         frame_s0 <= 1'b0;
         frame_s1 <= 1'b0;
         rx_frame <= 1'b0;
      end
      else
      begin
         frame_s0 <= rxi_frame;   // edge N
         frame_s1 <= frame_s0;
         rx_frame <= frame_s1;    // out at N+2 with the word
      end
   end

endmodule

// File: hdl/rx_io_pkg.sv
package rx_io_pkg;

   //##################################################
   //# capture side widths
   //##################################################

   localparam int LANE_W       = 8;            // pins per edge
   localparam int WORD_W       = 2 * LANE_W;   // two edges per cycle
   localparam int SAMPLE_WORDS = 7;            // words per full sample
   localparam int BURST_RELOAD = 3;            // ptr slot for burst words

   typedef logic [LANE_W-1:0] lane_t;          // one edge of rxi_data

   // first half cycle byte in [7:0], second in [15:8]
   typedef logic [WORD_W-1:0] word_t;

   // word k lives at [16k+15:16k]
   typedef logic [SAMPLE_WORDS*WORD_W-1:0] sample_t;

   // one bit per word slot
   typedef logic [SAMPLE_WORDS-1:0] ptr_t;

endpackage

// File: hdl/elink_pkg.sv
package elink_pkg;

   //##################################################
   //# mesh packet layout
   //##################################################

   localparam int PW       = 104;   // full packet width
   localparam int ADDR_W   = 32;    // dst / src address
   localparam int DATA_W   = 32;    // payload word
   localparam int CTRL_W   = 4;     // ctrlmode field
   localparam int DMODE_W  = 2;     // datamode field

   // one packet as seen by the mesh side
   // [0] access, [1] write, [3:2] datamode, [7:4] ctrlmode
   // [39:8] dstaddr, [71:40] data, [103:72] srcaddr
   typedef logic [PW-1:0]      packet_t;

   typedef logic [ADDR_W-1:0]  addr_t;      // dstaddr or srcaddr
   typedef logic [DATA_W-1:0]  data_t;      // write data
   typedef logic [CTRL_W-1:0]  ctrlmode_t;  // control mode
   typedef logic [DMODE_W-1:0] datamode_t;  // 0=byte .. 3=double

endpackage
